// ==== files.f ====
verilog/divsqrt_cfg_pkg.sv
verilog/divsqrt_ops_pkg.sv
verilog/divsqrt_pipe_stage.sv
verilog/divsqrt_iter_unit.sv
verilog/divsqrt_ctrl.sv
verilog/divsqrt_top.sv
verif/divsqrt_clk_gen.sv
verif/divsqrt_asserts.sv
verif/divsqrt_tb.sv

// ==== Bender.yml ====
# Bender manifest for the integer divide and square-root unit

package:
  name: divsqrt

dependencies: {}

sources:
  # Design sources, packages first
  - files:
      - verilog/divsqrt_cfg_pkg.sv
      - verilog/divsqrt_ops_pkg.sv
      - verilog/divsqrt_pipe_stage.sv
      - verilog/divsqrt_iter_unit.sv
      - verilog/divsqrt_ctrl.sv
      - verilog/divsqrt_top.sv

  # Verification sources, top module divsqrt_tb
  - target: simulation
    files:
      - verif/divsqrt_clk_gen.sv
      - verif/divsqrt_asserts.sv
      - verif/divsqrt_tb.sv

// ==== verif/divsqrt_tb.sv ====
// --------------------------------------
// Random traffic against a queue model
// Inputs change 1 ns after the rising edge
// Outputs are sampled at the falling edge
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_tb;

  import divsqrt_cfg_pkg::*;
  import divsqrt_ops_pkg::*;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   in_valid_i;
  logic                   in_ready_o;
  divsqrt_op_e            op_i;
  logic [DataWidth-1:0]   a_i;
  logic [DataWidth-1:0]   b_i;
  logic [TagWidth-1:0]    tag_i;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic [DataWidth-1:0]   result_o;
  logic                   dz_o;
  logic [TagWidth-1:0]    tag_o;
  logic                   flush_i;
  logic                   busy_o;

  // --------------------------------------
  // Scoreboard state
  // --------------------------------------
  integer                 seed;
  // Expected {result, dz, tag} in input order
  logic [OutPayloadW-1:0] exp_q[$];
  int                     n_checks;
  int                     n_mismatch;
  int                     n_other;
  int                     ops_left;
  bit                     timed_out;
  bit                     in_pending;
  bit                     hold_wait;
  bit                     after_flush;
  logic [DataWidth-1:0]   held_result;
  logic                   held_dz;
  logic [TagWidth-1:0]    held_tag;

  divsqrt_clk_gen u_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  divsqrt_top DUT (.*);

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    n_other++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  // --------------------------------------
  // Reference model
  // --------------------------------------
  // Largest r with r*r not above a
  function automatic logic [DataWidth-1:0] floor_sqrt(input logic [DataWidth-1:0] a);
    int unsigned r = 0;
    while ((r + 1) * (r + 1) <= a) begin
      r++;
    end
    return DataWidth'(r);
  endfunction

  function automatic logic [OutPayloadW-1:0] expected_entry(input divsqrt_op_e op,
      input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
      input logic [TagWidth-1:0] tag);
    logic [DataWidth-1:0] res;
    logic                 dz;
    dz = 1'b0;
    if (op == OP_SQRT) begin
      res = floor_sqrt(a);
    end else if (b == '0) begin
      // Zero divisor gives all ones and the flag
      res = '1;
      dz  = 1'b1;
    end else begin
      res = a / b;
    end
    return {res, dz, tag};
  endfunction

  // --------------------------------------
  // Stimulus
  // --------------------------------------
  task automatic new_request();
    int sel;
    sel   = $random(seed) & 7;
    op_i  = ($random(seed) & 1) ? OP_SQRT : OP_DIV;
    a_i   = DataWidth'($random(seed));
    tag_i = TagWidth'($random(seed));
    // Mix of zero, small and full-range divisors
    if (sel == 0) begin
      b_i = '0;
    end else if (sel < 4) begin
      b_i = DataWidth'($random(seed) & 'hff);
    end else begin
      b_i = DataWidth'($random(seed));
    end
    in_valid_i = 1'b1;
    in_pending = 1'b1;
    ops_left--;
  endtask

  // bp sets how often out_ready_i is low, 0 to 8 out of 8
  task automatic drive_inputs(input bit do_flush, input int bp);
    if (!in_pending) begin
      in_valid_i = 1'b0;
    end
    if (do_flush) begin
      flush_i     = 1'b1;
      in_valid_i  = 1'b0;
      in_pending  = 1'b0;
      out_ready_i = 1'b0;
    end else begin
      flush_i = 1'b0;
      // Random idle gaps between requests
      if (!in_pending && ops_left > 0 && ($random(seed) & 3) != 0) begin
        new_request();
      end
      out_ready_i = (($random(seed) & 7) >= bp);
    end
  endtask

  // --------------------------------------
  // Monitor, runs at the falling edge
  // --------------------------------------
  task automatic observe();
    logic [OutPayloadW-1:0] exp;
    if (flush_i) begin
      exp_q.delete();
      hold_wait   = 1'b0;
      after_flush = 1'b1;
    end else begin
      if (after_flush) begin
        compare("busy_o", busy_o, 0);
        compare("out_valid_o", out_valid_o, 0);
        after_flush = 1'b0;
      end
      // Refused result must not move
      if (hold_wait) begin
        compare("out_valid_o", out_valid_o, 1);
        compare("result_o", result_o, held_result);
        compare("dz_o", dz_o, held_dz);
        compare("tag_o", tag_o, held_tag);
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(expected_entry(op_i, a_i, b_i, tag_i));
        in_pending = 1'b0;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          report_failure("result delivered with no operation outstanding");
        end else begin
          exp = exp_q.pop_front();
          compare("result_o", result_o, exp[OutPayloadW-1 -: DataWidth]);
          compare("dz_o", dz_o, exp[TagWidth]);
          compare("tag_o", tag_o, exp[TagWidth-1:0]);
        end
      end
      hold_wait   = out_valid_o && !out_ready_i;
      held_result = result_o;
      held_dz     = dz_o;
      held_tag    = tag_o;
    end
  endtask

  task automatic tick(input bit do_flush, input int bp);
    @(posedge clk_i);
    #1;
    drive_inputs(do_flush, bp);
    @(negedge clk_i);
    observe();
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n_i !== 1'b1 && !timed_out) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 100) begin
        report_failure("reset was not released within 100 cycles");
        timed_out = 1'b1;
      end
    end
  endtask

  // Runs until n_ops are accepted, and drained if asked
  task automatic run_traffic(input int n_ops, input bit drain, input int bp);
    int cycles;
    cycles   = 0;
    ops_left = n_ops;
    while (!timed_out && (ops_left > 0 || in_pending || (drain && exp_q.size() != 0))) begin
      tick(1'b0, bp);
      cycles++;
      if (cycles > n_ops * 100 + 200) begin
        report_failure("traffic did not complete in time, unit appears stuck");
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    seed        = 93012;
    n_checks    = 0;
    n_mismatch  = 0;
    n_other     = 0;
    ops_left    = 0;
    timed_out   = 1'b0;
    in_pending  = 1'b0;
    hold_wait   = 1'b0;
    after_flush = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    a_i         = '0;
    b_i         = '0;
    tag_i       = '0;
    out_ready_i = 1'b0;
    flush_i     = 1'b0;

    wait_reset_release();
    if (!timed_out) begin
      compare("out_valid_o", out_valid_o, 0);
      compare("busy_o", busy_o, 0);
      compare("in_ready_o", in_ready_o, 1);
      // Light back-pressure
      run_traffic(150, 1'b1, 3);
    end
    // Leave work in flight, then flush it
    if (!timed_out) begin
      run_traffic(4, 1'b0, 5);
    end
    if (!timed_out) begin
      tick(1'b1, 0);
      // Heavy back-pressure after the flush
      run_traffic(60, 1'b1, 6);
    end
    if (!timed_out) begin
      repeat (4) tick(1'b0, 0);
      compare("busy_o", busy_o, 0);
    end

    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verif/divsqrt_asserts.sv ====
// --------------------------------------
// Handshake and flush properties
// Attached to every divsqrt_top instance
// Flush cycles are exempt from hold rules
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_asserts (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                                 flush_i,
  input logic                                 in_valid_i,
  input logic                                 in_ready_i,
  input logic                                 out_valid_i,
  input logic                                 out_ready_i,
  input logic [divsqrt_cfg_pkg::DataWidth-1:0] result_i,
  input logic                                 dz_i,
  input logic [divsqrt_cfg_pkg::TagWidth-1:0]  tag_i,
  input logic                                 busy_i
);

  // Request stays up until the input stage takes it
  a_in_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    in_valid_i && !in_ready_i |=> in_valid_i)
    else $error("in_valid_i dropped before it was accepted");

  // Refused result keeps its value
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i) && $stable(dz_i)
      && $stable(tag_i))
    else $error("output changed while waiting for out_ready_i");

  // Quiet and ready right after reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !out_valid_i && !busy_i && in_ready_i)
    else $error("unit not idle after reset");

  // Flush empties the unit in one cycle
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i && !busy_i)
    else $error("unit not idle after flush");

  a_busy_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> busy_i)
    else $error("busy_o low while out_valid_o is high");

endmodule

bind divsqrt_top divsqrt_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .dz_i        (dz_o),
  .tag_i       (tag_o),
  .busy_i      (busy_o)
);

// ==== verif/divsqrt_clk_gen.sv ====
// --------------------------------------
// Clock and reset for the testbench
// 4 ns clock, reset low for 16 cycles
// Reset is released 1 ns after an edge
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Half period of 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== verilog/divsqrt_top.sv ====
// --------------------------------------
// Divide/sqrt unit, elastic in and out
// Up to three ops in flight, kept in order
// Flush clears all state in one cycle
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Request side
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  divsqrt_ops_pkg::divsqrt_op_e         op_i,
  input  logic [divsqrt_cfg_pkg::DataWidth-1:0] a_i,
  input  logic [divsqrt_cfg_pkg::DataWidth-1:0] b_i,
  input  logic [divsqrt_cfg_pkg::TagWidth-1:0]  tag_i,
  // Response side
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic [divsqrt_cfg_pkg::DataWidth-1:0] result_o,
  output logic                                 dz_o,
  output logic [divsqrt_cfg_pkg::TagWidth-1:0]  tag_o,
  // Control and status
  input  logic                                 flush_i,
  output logic                                 busy_o
);

  import divsqrt_cfg_pkg::*;
  import divsqrt_ops_pkg::*;

  // --------------------------------------
  // Internal wires
  // --------------------------------------
  logic                   in_valid_q;
  logic                   in_ready_q;
  logic [InPayloadW-1:0]  in_data_q;
  logic                   ctrl_out_valid;
  logic                   ctrl_out_ready;
  logic [DataWidth-1:0]   ctrl_result;
  logic                   ctrl_dz;
  logic [TagWidth-1:0]    ctrl_tag;
  logic                   ctrl_busy;
  logic                   unit_start;
  logic                   unit_ready;
  logic                   unit_done;
  logic [DataWidth-1:0]   unit_result;
  logic                   unit_dz;
  logic                   out_valid_q;
  logic [OutPayloadW-1:0] out_data_q;

  // Input stage, payload is {op, a, b, tag}
  divsqrt_pipe_stage #(
    .PayloadW (InPayloadW)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  ({op_i, a_i, b_i, tag_i}),
    .valid_o (in_valid_q),
    .ready_i (in_ready_q),
    .data_o  (in_data_q)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .in_valid_i    (in_valid_q),
    .in_ready_o    (in_ready_q),
    .tag_i         (in_data_q[TagWidth-1:0]),
    .unit_ready_i  (unit_ready),
    .unit_done_i   (unit_done),
    .unit_result_i (unit_result),
    .unit_dz_i     (unit_dz),
    .start_o       (unit_start),
    .out_valid_o   (ctrl_out_valid),
    .out_ready_i   (ctrl_out_ready),
    .result_o      (ctrl_result),
    .dz_o          (ctrl_dz),
    .tag_o         (ctrl_tag),
    .busy_o        (ctrl_busy)
  );

  // Flush also aborts the running op
  divsqrt_iter_unit u_unit (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (unit_start),
    .op_i     (divsqrt_op_e'(in_data_q[InPayloadW-1])),
    .a_i      (in_data_q[TagWidth+DataWidth +: DataWidth]),
    .b_i      (in_data_q[TagWidth +: DataWidth]),
    .kill_i   (flush_i),
    .ready_o  (unit_ready),
    .done_o   (unit_done),
    .result_o (unit_result),
    .dz_o     (unit_dz)
  );

  // Output stage, payload is {result, dz, tag}
  divsqrt_pipe_stage #(
    .PayloadW (OutPayloadW)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (ctrl_out_valid),
    .ready_o (ctrl_out_ready),
    .data_i  ({ctrl_result, ctrl_dz, ctrl_tag}),
    .valid_o (out_valid_q),
    .ready_i (out_ready_i),
    .data_o  (out_data_q)
  );

  assign out_valid_o = out_valid_q;
  assign result_o    = out_data_q[OutPayloadW-1 -: DataWidth];
  assign dz_o        = out_data_q[TagWidth];
  assign tag_o       = out_data_q[TagWidth-1:0];
  // Anything held in either stage or in the core
  assign busy_o      = in_valid_q | ctrl_busy | out_valid_q;

endmodule

// ==== verilog/divsqrt_ctrl.sv ====
// --------------------------------------
// Control FSM between stages and core
// Starts only when the core is ready
// A refused result waits in the hold reg
// Flush wins over every other action
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 flush_i,
  // Input stage side
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  input  logic [divsqrt_cfg_pkg::TagWidth-1:0]  tag_i,
  // Core side
  input  logic                                 unit_ready_i,
  input  logic                                 unit_done_i,
  input  logic [divsqrt_cfg_pkg::DataWidth-1:0] unit_result_i,
  input  logic                                 unit_dz_i,
  output logic                                 start_o,
  // Output stage side
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic [divsqrt_cfg_pkg::DataWidth-1:0] result_o,
  output logic                                 dz_o,
  output logic [divsqrt_cfg_pkg::TagWidth-1:0]  tag_o,
  // Status
  output logic                                 busy_o
);

  import divsqrt_cfg_pkg::*;
  import divsqrt_ops_pkg::*;

  ctrl_state_e          state_q;
  ctrl_state_e          state_d;
  logic                 in_ready;
  logic                 out_valid;
  logic                 busy;
  logic                 hold_en;
  logic [TagWidth-1:0]  tag_q;
  logic [DataWidth-1:0] held_result_q;
  logic                 held_dz_q;

  // --------------------------------------
  // Next state and handshakes
  // --------------------------------------
  always_comb begin
    in_ready  = 1'b0;
    out_valid = 1'b0;
    busy      = 1'b0;
    hold_en   = 1'b0;
    state_d   = state_q;

    unique case (state_q)
      ST_IDLE: begin
        in_ready = unit_ready_i;
        if (in_valid_i && unit_ready_i) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        busy = 1'b1;
        if (unit_done_i) begin
          out_valid = 1'b1;
          if (out_ready_i) begin
            // Result leaves now, next op may start in the same cycle
            state_d  = ST_IDLE;
            in_ready = unit_ready_i;
            if (in_valid_i && unit_ready_i) begin
              state_d = ST_BUSY;
            end
          end else begin
            // Park the result until downstream has room
            hold_en = 1'b1;
            state_d = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        busy      = 1'b1;
        out_valid = 1'b1;
        if (out_ready_i) begin
          state_d  = ST_IDLE;
          in_ready = unit_ready_i;
          if (in_valid_i && unit_ready_i) begin
            state_d = ST_BUSY;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase

    // Flush drops everything in flight
    if (flush_i) begin
      in_ready  = 1'b0;
      out_valid = 1'b0;
      busy      = 1'b0;
      hold_en   = 1'b0;
      state_d   = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------
  // Tag and hold registers
  // --------------------------------------
  assign start_o = in_valid_i & in_ready;

  // Tag follows the op through the core
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= tag_i;
    end
    if (hold_en) begin
      held_result_q <= unit_result_i;
      held_dz_q     <= unit_dz_i;
    end
  end

  // Held value has priority while parked
  assign result_o    = (state_q == ST_HOLD) ? held_result_q : unit_result_i;
  assign dz_o        = (state_q == ST_HOLD) ? held_dz_q : unit_dz_i;
  assign tag_o       = tag_q;
  assign in_ready_o  = in_ready;
  assign out_valid_o = out_valid;
  assign busy_o      = busy;

endmodule

// ==== verilog/divsqrt_iter_unit.sv ====
// --------------------------------------
// Iterative unsigned divide and sqrt core
// One result bit per cycle and one op at a time
// Divide by zero returns all ones and sets dz
// Start is ignored while busy
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_iter_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 start_i,
  input  divsqrt_ops_pkg::divsqrt_op_e         op_i,
  input  logic [divsqrt_cfg_pkg::DataWidth-1:0] a_i,
  input  logic [divsqrt_cfg_pkg::DataWidth-1:0] b_i,
  input  logic                                 kill_i,
  output logic                                 ready_o,
  output logic                                 done_o,
  output logic [divsqrt_cfg_pkg::DataWidth-1:0] result_o,
  output logic                                 dz_o
);

  import divsqrt_cfg_pkg::*;
  import divsqrt_ops_pkg::*;

  // --------------------------------------
  // State
  // --------------------------------------
  logic                  busy_q;
  logic                  done_q;
  logic [CountWidth-1:0] cnt_q;
  logic                  launch;

  // Working registers
  divsqrt_op_e           op_q;
  logic [DataWidth-1:0]  div_q;
  // Dividend or radicand shifted out from the top
  logic [DataWidth-1:0]  quo_q;
  logic [DataWidth-1:0]  rem_q;
  logic [SqrtIters-1:0]  root_q;
  // Only set for a divide by zero
  logic                  dz_q;

  // --------------------------------------
  // Restoring divide step
  // --------------------------------------
  logic [DataWidth:0]    div_shift;
  logic [DataWidth+1:0]  div_diff;
  logic                  div_neg;

  // Bring down the next dividend bit
  assign div_shift = {rem_q, quo_q[DataWidth-1]};
  // Extra top bit gives the sign of the trial
  assign div_diff  = {1'b0, div_shift} - {2'b00, div_q};
  assign div_neg   = div_diff[DataWidth+1];

  // --------------------------------------
  // Digit-by-digit sqrt step
  // --------------------------------------
  logic [DataWidth-1:0]  sq_shift;
  logic [DataWidth-1:0]  sq_trial;
  logic [DataWidth:0]    sq_diff;
  logic                  sq_neg;

  // Bring down the next pair of radicand bits
  // Top two rem bits are always zero here
  assign sq_shift = {rem_q[DataWidth-3:0], quo_q[DataWidth-1:DataWidth-2]};
  // Trial subtrahend is 4*root + 1
  assign sq_trial = {{(DataWidth-SqrtIters-2){1'b0}}, root_q, 2'b01};
  assign sq_diff  = {1'b0, sq_shift} - {1'b0, sq_trial};
  assign sq_neg   = sq_diff[DataWidth];

  // --------------------------------------
  // Sequencing
  // --------------------------------------
  assign launch = start_i & ~busy_q;

  // Done pulses one cycle after the last step
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || kill_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (launch) begin
        busy_q <= 1'b1;
        cnt_q  <= (op_i == OP_DIV) ? CountWidth'(DivIters) : CountWidth'(SqrtIters);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        // Result is final after this step
        if (cnt_q == CountWidth'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (launch) begin
      op_q   <= op_i;
      div_q  <= b_i;
      quo_q  <= a_i;
      rem_q  <= '0;
      root_q <= '0;
      dz_q   <= (op_i == OP_DIV) && (b_i == '0);
    end else if (busy_q) begin
      if (op_q == OP_DIV) begin
        // Restore on a negative trial
        // Quotient bit enters at the bottom
        rem_q <= div_neg ? div_shift[DataWidth-1:0] : div_diff[DataWidth-1:0];
        quo_q <= {quo_q[DataWidth-2:0], ~div_neg};
      end else begin
        rem_q  <= sq_neg ? sq_shift : sq_diff[DataWidth-1:0];
        quo_q  <= {quo_q[DataWidth-3:0], 2'b00};
        root_q <= {root_q[SqrtIters-2:0], ~sq_neg};
      end
    end
  end

  // --------------------------------------
  // Outputs
  // --------------------------------------
  assign ready_o  = ~busy_q;
  assign done_o   = done_q;
  // b of zero already leaves all ones in quo_q
  assign result_o = (op_q == OP_DIV) ? quo_q : {{(DataWidth-SqrtIters){1'b0}}, root_q};
  assign dz_o     = dz_q;

endmodule

// ==== verilog/divsqrt_pipe_stage.sv ====
// --------------------------------------
// One elastic register stage
// Full throughput, ready is combinational
// Flush drops the held item
// --------------------------------------

`timescale 1ns/1ps

module divsqrt_pipe_stage #(
  parameter int unsigned PayloadW = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // Upstream side
  input  logic                valid_i,
  output logic                ready_o,
  input  logic [PayloadW-1:0] data_i,
  // Downstream side
  output logic                valid_o,
  input  logic                ready_i,
  output logic [PayloadW-1:0] data_o
);

  logic                valid_q;
  logic [PayloadW-1:0] data_q;
  logic                load;

  // Take new data when empty or when the current item leaves
  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  // Valid flag, cleared by reset and by flush
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== verilog/divsqrt_ops_pkg.sv ====
// --------------------------------------
// Opcodes and control FSM states
// Opcode is one bit wide in the payload
// --------------------------------------

package divsqrt_ops_pkg;

  // --------------------------------------
  // Operation select
  // --------------------------------------
  // OP_DIV gives a / b, quotient only
  // OP_SQRT gives floor(sqrt(a)), b unused
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // --------------------------------------
  // Control FSM
  // --------------------------------------
  // Idle waits for work
  // Busy waits for the core to finish
  // Hold keeps a result that downstream refused
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_HOLD = 2'd2
  } ctrl_state_e;

endpackage

// ==== verilog/divsqrt_cfg_pkg.sv ====
// --------------------------------------
// Sizes for the integer divide/sqrt unit
// Operands and result are unsigned
// Sqrt needs an even DataWidth
// --------------------------------------

package divsqrt_cfg_pkg;

  // --------------------------------------
  // Datapath widths
  // --------------------------------------
  // Operand and result width
  localparam int unsigned DataWidth = 16;
  // Tag carried along with every operation
  localparam int unsigned TagWidth  = 4;

  // --------------------------------------
  // Iteration counts
  // --------------------------------------
  // One quotient bit per cycle
  localparam int unsigned DivIters   = DataWidth;
  // One root bit per pair of operand bits
  localparam int unsigned SqrtIters  = DataWidth / 2;
  // Counter must hold the longest run
  localparam int unsigned CountWidth = $clog2(DivIters + 1);

  // --------------------------------------
  // Stage payloads
  // --------------------------------------
  // Opcode bit, a, b and tag
  localparam int unsigned InPayloadW  = 1 + 2 * DataWidth + TagWidth;
  // Result, divide-by-zero flag and tag
  localparam int unsigned OutPayloadW = DataWidth + 1 + TagWidth;

endpackage
